/* design/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Data path widths
`define CONV_DATA_W 16
`define CONV_ACC_W 32

`define CONV_NB_BUSSES 3

// Convolution shape
`define CONV_TAPS 9
`define CONV_IN_CH 2
`define CONV_OUT_CH 4
`define CONV_MAP_W 4
`define CONV_MAP_H 4

`define CONV_OUTPUT_SHIFT 0

// Bus transfers per phase
`define CONV_KERNEL_BEATS 36
`define CONV_WINDOW_BEATS 6
`define CONV_RESULT_BEATS 2

`endif

/* design/conv_pkg.sv */
`include "conv_macros.svh"

package conv_pkg;

  typedef logic signed [`CONV_DATA_W-1:0] word_t;
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // Index 0 is bus_1
  typedef word_t [`CONV_NB_BUSSES-1:0] bus_beat_t;

  // Flat word order is output channel, then input channel, then tap
  typedef word_t [`CONV_OUT_CH-1:0][`CONV_IN_CH-1:0][`CONV_TAPS-1:0] kernel_t;

  typedef word_t [`CONV_IN_CH-1:0][`CONV_TAPS-1:0] window_t;

  typedef word_t [`CONV_OUT_CH-1:0] result_t;

  // Output coordinates and channel
  typedef logic [$clog2(`CONV_MAP_W)-1:0] x_t;
  typedef logic [$clog2(`CONV_MAP_H)-1:0] y_t;
  typedef logic [$clog2(`CONV_OUT_CH)-1:0] ch_t;

endpackage

/* design/bus_port_if.sv */
interface bus_port_if;
  import conv_pkg::*;

  logic req;
  logic gnt;
  // One pulse per completed beat
  logic fire;
  bus_beat_t rd_data;
  bus_beat_t wr_data;

  modport requester (
    output req,
    input  gnt,
    input  fire,
    input  rd_data,
    output wr_data
  );

  modport arbiter (
    input  req,
    output gnt,
    output fire,
    output rd_data,
    input  wr_data
  );

endinterface

/* design/bus_arbiter.sv */
module bus_arbiter (
  input  logic clk,
  input  logic arst_n,
  inout  wire conv_pkg::word_t bus_1,
  inout  wire conv_pkg::word_t bus_2,
  inout  wire conv_pkg::word_t bus_3,
  input  logic bus_valid,
  output logic bus_ready,
  output logic driving_busses,
  bus_port_if.arbiter load_port,
  bus_port_if.arbiter unload_port
);
  import conv_pkg::*;

  // Quiet cycles with bus_ready low before the busses turn around
  localparam int TURN_CYCLES = 2;

  typedef enum logic {OWNER_LOAD, OWNER_UNLOAD} owner_e;

  owner_e grant_q;
  logic [$clog2(TURN_CYCLES+1)-1:0] turn_q;
  bus_beat_t drive_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      grant_q <= OWNER_LOAD;
      turn_q <= '0;
    end else begin
      // Owner keeps the busses until it lowers req
      case (grant_q)
        OWNER_LOAD: if (!load_port.req && unload_port.req) grant_q <= OWNER_UNLOAD;
        default: if (!unload_port.req) grant_q <= OWNER_LOAD;
      endcase
      if (grant_q == OWNER_LOAD) begin
        turn_q <= '0;
      end else if (turn_q != TURN_CYCLES) begin
        turn_q <= turn_q + 1'b1;
      end
    end
  end

  assign load_port.gnt = (grant_q == OWNER_LOAD);
  assign unload_port.gnt = (grant_q == OWNER_UNLOAD);

  assign bus_ready = load_port.gnt && load_port.req;
  assign driving_busses = unload_port.gnt && unload_port.req && (turn_q == TURN_CYCLES);

  assign load_port.fire = bus_valid && bus_ready;
  assign unload_port.fire = driving_busses;

  // Only the unloader ever drives the busses
  assign drive_data = unload_port.wr_data;

  assign bus_1 = driving_busses ? drive_data[0] : 'z;
  assign bus_2 = driving_busses ? drive_data[1] : 'z;
  assign bus_3 = driving_busses ? drive_data[2] : 'z;

  assign load_port.rd_data = {bus_3, bus_2, bus_1};
  assign unload_port.rd_data = {bus_3, bus_2, bus_1};

endmodule

/* design/operand_loader.sv */
`include "conv_macros.svh"

module operand_loader (
  input  logic clk,
  input  logic arst_n,
  input  logic running,
  bus_port_if.requester port,
  input  logic busy,
  output conv_pkg::kernel_t kernel,
  output conv_pkg::window_t window,
  output logic window_valid
);
  import conv_pkg::*;

  localparam int NB_KERNEL_WORDS = `CONV_OUT_CH * `CONV_IN_CH * `CONV_TAPS;
  localparam int NB_WINDOW_WORDS = `CONV_IN_CH * `CONV_TAPS;
  localparam int NB_PIXELS = `CONV_MAP_W * `CONV_MAP_H;
  localparam int KERNEL_PER_BEAT = NB_KERNEL_WORDS / `CONV_KERNEL_BEATS;
  localparam int WINDOW_PER_BEAT = NB_WINDOW_WORDS / `CONV_WINDOW_BEATS;
  localparam int BEAT_W = $clog2(`CONV_KERNEL_BEATS);

  typedef enum logic [1:0] {PHASE_KERNEL, PHASE_WINDOW, PHASE_DONE} phase_e;

  phase_e phase_q;
  logic [BEAT_W-1:0] beat_q;
  logic [$clog2(NB_PIXELS)-1:0] win_cnt_q;
  logic buf_full_q;
  logic last_beat;
  word_t [NB_KERNEL_WORDS-1:0] kernel_q;
  word_t [NB_WINDOW_WORDS-1:0] next_q;

  assign last_beat = (phase_q == PHASE_KERNEL) ?
                     (beat_q == BEAT_W'(`CONV_KERNEL_BEATS - 1)) :
                     (beat_q == BEAT_W'(`CONV_WINDOW_BEATS - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase_q <= PHASE_KERNEL;
      beat_q <= '0;
      win_cnt_q <= '0;
      buf_full_q <= 1'b0;
    end else if (!running) begin
      phase_q <= PHASE_KERNEL;
      beat_q <= '0;
      win_cnt_q <= '0;
      buf_full_q <= 1'b0;
    end else begin
      if (port.fire) begin
        if (last_beat) begin
          beat_q <= '0;
          if (phase_q == PHASE_KERNEL) begin
            phase_q <= PHASE_WINDOW;
          end else begin
            buf_full_q <= 1'b1;
            win_cnt_q <= win_cnt_q + 1'b1;
            // No more windows after the last pixel, so the bus stays free for results
            if (win_cnt_q == NB_PIXELS - 1) phase_q <= PHASE_DONE;
          end
        end else begin
          beat_q <= beat_q + 1'b1;
        end
      end
      if (window_valid) buf_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (port.fire && phase_q == PHASE_KERNEL) begin
      for (int i = 0; i < KERNEL_PER_BEAT; i++) begin
        kernel_q[KERNEL_PER_BEAT * beat_q + i] <= port.rd_data[i];
      end
    end
    if (port.fire && phase_q == PHASE_WINDOW) begin
      for (int i = 0; i < WINDOW_PER_BEAT; i++) begin
        next_q[WINDOW_PER_BEAT * beat_q + i] <= port.rd_data[i];
      end
    end
  end

  assign port.req = running && !buf_full_q && (phase_q != PHASE_DONE);
  // Loader never drives the busses
  assign port.wr_data = '0;

  assign kernel = kernel_q;
  assign window = next_q;
  assign window_valid = buf_full_q && !busy;

endmodule

/* design/mac_array.sv */
`include "conv_macros.svh"

module mac_array (
  input  logic clk,
  input  logic arst_n,
  input  conv_pkg::kernel_t kernel,
  input  conv_pkg::window_t window,
  input  logic window_valid,
  output logic busy,
  output conv_pkg::result_t results,
  output logic result_valid,
  input  logic result_taken
);
  import conv_pkg::*;

  localparam int TAP_W = $clog2(`CONV_TAPS);

  window_t feat_q;
  acc_t [`CONV_OUT_CH-1:0][`CONV_IN_CH-1:0] acc_q;
  acc_t [`CONV_OUT_CH-1:0][`CONV_IN_CH-1:0] prod;
  acc_t [`CONV_OUT_CH-1:0] ch_sum;
  result_t results_q;
  logic [TAP_W-1:0] tap_q;
  logic run_q;
  logic sum_q;
  logic busy_q;
  logic result_valid_q;

  // Scale down and clip to the signed word range
  function automatic word_t saturate(acc_t value);
    acc_t shifted;
    acc_t max_v;
    acc_t min_v;
    shifted = value >>> `CONV_OUTPUT_SHIFT;
    max_v = (acc_t'(1) <<< (`CONV_DATA_W - 1)) - 1;
    min_v = -max_v - 1;
    if (shifted > max_v) return word_t'(max_v);
    if (shifted < min_v) return word_t'(min_v);
    return word_t'(shifted);
  endfunction

  always_comb begin
    for (int oc = 0; oc < `CONV_OUT_CH; oc++) begin
      for (int ic = 0; ic < `CONV_IN_CH; ic++) begin
        prod[oc][ic] = acc_t'($signed(feat_q[ic][tap_q])) *
                       acc_t'($signed(kernel[oc][ic][tap_q]));
      end
    end
  end

  // Channel summing stage
  always_comb begin
    for (int oc = 0; oc < `CONV_OUT_CH; oc++) begin
      ch_sum[oc] = '0;
      for (int ic = 0; ic < `CONV_IN_CH; ic++) begin
        ch_sum[oc] = ch_sum[oc] + acc_q[oc][ic];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tap_q <= '0;
      run_q <= 1'b0;
      sum_q <= 1'b0;
      busy_q <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      if (window_valid) begin
        busy_q <= 1'b1;
        run_q <= 1'b1;
        tap_q <= '0;
      end else if (result_taken) begin
        busy_q <= 1'b0;
      end
      if (run_q) begin
        if (tap_q == TAP_W'(`CONV_TAPS - 1)) begin
          run_q <= 1'b0;
          sum_q <= 1'b1;
        end else begin
          tap_q <= tap_q + 1'b1;
        end
      end
      if (sum_q) begin
        sum_q <= 1'b0;
        result_valid_q <= 1'b1;
      end else if (result_taken) begin
        result_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (window_valid) feat_q <= window;
    if (run_q) begin
      for (int oc = 0; oc < `CONV_OUT_CH; oc++) begin
        for (int ic = 0; ic < `CONV_IN_CH; ic++) begin
          // First tap restarts the accumulation
          if (tap_q == '0) acc_q[oc][ic] <= prod[oc][ic];
          else acc_q[oc][ic] <= acc_q[oc][ic] + prod[oc][ic];
        end
      end
    end
    if (sum_q) begin
      for (int oc = 0; oc < `CONV_OUT_CH; oc++) begin
        results_q[oc] <= saturate(ch_sum[oc]);
      end
    end
  end

  assign busy = busy_q;
  assign results = results_q;
  assign result_valid = result_valid_q;

endmodule

/* design/result_unloader.sv */
`include "conv_macros.svh"

module result_unloader (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  output logic running,
  input  conv_pkg::result_t results,
  input  logic result_valid,
  output logic result_taken,
  bus_port_if.requester port,
  output logic output_valid,
  output conv_pkg::x_t output_x,
  output conv_pkg::y_t output_y,
  output conv_pkg::ch_t output_ch
);
  import conv_pkg::*;

  localparam logic LAST_BEAT = 1'(`CONV_RESULT_BEATS - 1);

  logic running_q;
  logic beat_q;
  x_t x_q;
  y_t y_q;
  logic last_x;
  logic last_pixel;
  bus_beat_t beat_data;

  assign last_x = (x_q == x_t'(`CONV_MAP_W - 1));
  assign last_pixel = last_x && (y_q == y_t'(`CONV_MAP_H - 1));
  assign result_taken = port.fire && (beat_q == LAST_BEAT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running_q <= 1'b0;
      beat_q <= 1'b0;
      x_q <= '0;
      y_q <= '0;
    end else if (start && !running_q) begin
      running_q <= 1'b1;
      beat_q <= 1'b0;
      x_q <= '0;
      y_q <= '0;
    end else if (port.fire) begin
      if (beat_q == LAST_BEAT) begin
        beat_q <= 1'b0;
        // Raster order, x fastest
        if (last_x) begin
          x_q <= '0;
          y_q <= last_pixel ? '0 : y_q + 1'b1;
        end else begin
          x_q <= x_q + 1'b1;
        end
        if (last_pixel) running_q <= 1'b0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Unused busses of the last beat carry zero
  always_comb begin
    int ch;
    beat_data = '0;
    for (int i = 0; i < `CONV_NB_BUSSES; i++) begin
      ch = beat_q * `CONV_NB_BUSSES + i;
      if (ch < `CONV_OUT_CH) beat_data[i] = results[ch];
    end
  end

  assign port.req = result_valid;
  assign port.wr_data = beat_data;

  assign running = running_q;
  assign output_valid = port.fire;
  assign output_x = x_q;
  assign output_y = y_q;
  assign output_ch = ch_t'(beat_q * `CONV_NB_BUSSES);

endmodule

/* design/conv_top.sv */
module conv_top (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  output logic running,
  inout  wire conv_pkg::word_t bus_1,
  inout  wire conv_pkg::word_t bus_2,
  inout  wire conv_pkg::word_t bus_3,
  input  logic bus_valid,
  output logic bus_ready,
  output logic driving_busses,
  output logic output_valid,
  output conv_pkg::x_t output_x,
  output conv_pkg::y_t output_y,
  output conv_pkg::ch_t output_ch
);
  import conv_pkg::*;

  kernel_t kernel;
  window_t window;
  logic window_valid;
  logic busy;
  result_t results;
  logic result_valid;
  logic result_taken;

  bus_port_if load_port ();
  bus_port_if unload_port ();

  bus_arbiter arbiter_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .bus_1          (bus_1),
    .bus_2          (bus_2),
    .bus_3          (bus_3),
    .bus_valid      (bus_valid),
    .bus_ready      (bus_ready),
    .driving_busses (driving_busses),
    .load_port      (load_port.arbiter),
    .unload_port    (unload_port.arbiter)
  );

  operand_loader loader_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .running      (running),
    .port         (load_port.requester),
    .busy         (busy),
    .kernel       (kernel),
    .window       (window),
    .window_valid (window_valid)
  );

  mac_array mac_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .kernel       (kernel),
    .window       (window),
    .window_valid (window_valid),
    .busy         (busy),
    .results      (results),
    .result_valid (result_valid),
    .result_taken (result_taken)
  );

  result_unloader unloader_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .running      (running),
    .results      (results),
    .result_valid (result_valid),
    .result_taken (result_taken),
    .port         (unload_port.requester),
    .output_valid (output_valid),
    .output_x     (output_x),
    .output_y     (output_y),
    .output_ch    (output_ch)
  );

endmodule

/* verification/clk_gen.sv */
module clk_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

/* verification/conv_tb.sv */
`include "conv_macros.svh"

module conv_tb;
  import conv_pkg::*;

  localparam int NB_PIXELS = `CONV_MAP_W * `CONV_MAP_H;
  localparam int KERNEL_WORDS = `CONV_OUT_CH * `CONV_IN_CH * `CONV_TAPS;
  localparam int WINDOW_WORDS = `CONV_IN_CH * `CONV_TAPS;
  localparam int KERNEL_PER_BEAT = KERNEL_WORDS / `CONV_KERNEL_BEATS;
  localparam int RESULT_BASE = KERNEL_WORDS + NB_PIXELS * WINDOW_WORDS;
  localparam int STIM_WORDS = RESULT_BASE + NB_PIXELS * `CONV_OUT_CH;
  localparam int IN_BEATS = `CONV_KERNEL_BEATS + NB_PIXELS * `CONV_WINDOW_BEATS;
  localparam int OUT_BEATS = NB_PIXELS * `CONV_RESULT_BEATS;
  localparam int BEAT_TIMEOUT = 200;
  localparam int DONE_TIMEOUT = 400;
  localparam int QUIET_CYCLES = 50;

  logic clk;
  logic arst_n;
  logic start;
  logic bus_valid;
  logic [`CONV_DATA_W-1:0] host_data [`CONV_NB_BUSSES];
  wire [`CONV_DATA_W-1:0] bus_1;
  wire [`CONV_DATA_W-1:0] bus_2;
  wire [`CONV_DATA_W-1:0] bus_3;
  logic running;
  logic bus_ready;
  logic driving_busses;
  logic output_valid;
  x_t output_x;
  y_t output_y;
  ch_t output_ch;

  logic [`CONV_DATA_W-1:0] stim_mem [0:STIM_WORDS-1];
  integer seed;
  int out_beats = 0;
  logic [1:0] ready_hist = 2'b11;
  logic ready_seen = 1'b0;
  logic running_low_due = 1'b0;

  // Host drives the busses only together with bus_valid
  assign bus_1 = bus_valid ? host_data[0] : 'z;
  assign bus_2 = bus_valid ? host_data[1] : 'z;
  assign bus_3 = bus_valid ? host_data[2] : 'z;

  clk_gen clk_gen_i (
    .clk (clk)
  );

  conv_top dut_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .running        (running),
    .bus_1          (bus_1),
    .bus_2          (bus_2),
    .bus_3          (bus_3),
    .bus_valid      (bus_valid),
    .bus_ready      (bus_ready),
    .driving_busses (driving_busses),
    .output_valid   (output_valid),
    .output_x       (output_x),
    .output_y       (output_y),
    .output_ch      (output_ch)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at time %0t: %s is %0h, expected %0h",
                          $time, name, actual, expected));
    end
  endtask

  // Puts transfer idx of the load sequence on the busses
  task automatic present_beat(input int idx);
    int base;
    if (idx < `CONV_KERNEL_BEATS) begin
      host_data[0] <= stim_mem[KERNEL_PER_BEAT * idx];
      host_data[1] <= stim_mem[KERNEL_PER_BEAT * idx + 1];
      // Filler on bus_3, ignored during the kernel phase
      host_data[2] <= 16'h5a5a;
    end else begin
      base = KERNEL_WORDS + (idx - `CONV_KERNEL_BEATS) * `CONV_NB_BUSSES;
      host_data[0] <= stim_mem[base];
      host_data[1] <= stim_mem[base + 1];
      host_data[2] <= stim_mem[base + 2];
    end
    bus_valid <= 1'b1;
  endtask

  // Output and bus monitor, sampled mid-cycle
  always @(negedge clk) begin
    int pixel;
    int base;
    if (arst_n === 1'b1) begin
      if (running_low_due) check_value("running", running, 1'b0);
      running_low_due = 1'b0;
      if (bus_valid) begin
        check_value("bus_1", bus_1, host_data[0]);
        check_value("bus_2", bus_2, host_data[1]);
        check_value("bus_3", bus_3, host_data[2]);
      end
      if (driving_busses) begin
        check_value("bus_ready history", ready_hist, 2'b00);
        check_value("bus_valid", bus_valid, 1'b0);
      end
      if (output_valid && out_beats >= OUT_BEATS) begin
        abort_run("An output beat appeared after the last pixel");
      end else if (output_valid) begin
        pixel = out_beats / `CONV_RESULT_BEATS;
        base = RESULT_BASE + pixel * `CONV_OUT_CH;
        check_value("output_x", output_x, pixel % `CONV_MAP_W);
        check_value("output_y", output_y, pixel / `CONV_MAP_W);
        if (out_beats % `CONV_RESULT_BEATS == 0) begin
          check_value("output_ch", output_ch, 0);
          check_value("bus_1", bus_1, stim_mem[base]);
          check_value("bus_2", bus_2, stim_mem[base + 1]);
          check_value("bus_3", bus_3, stim_mem[base + 2]);
        end else begin
          check_value("output_ch", output_ch, 3);
          check_value("bus_1", bus_1, stim_mem[base + 3]);
          check_value("bus_2", bus_2, 0);
          check_value("bus_3", bus_3, 0);
          if (pixel == NB_PIXELS - 1) running_low_due = 1'b1;
        end
        out_beats++;
      end
    end
    ready_hist = {ready_hist[0], bus_ready};
    ready_seen = bus_ready;
  end

  initial begin
    int beat;
    int idle_cycles;
    int wait_cycles;
    seed = 32'h4177_359b;
    arst_n = 1'b0;
    start = 1'b0;
    bus_valid = 1'b0;
    for (int i = 0; i < `CONV_NB_BUSSES; i++) begin
      host_data[i] = '0;
    end
    $readmemh("verification/conv_stim.mem", stim_mem);
    if ($isunknown(stim_mem[STIM_WORDS-1])) abort_run("Stimulus file is missing or too short");

    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    @(negedge clk);
    check_value("running", running, 1'b0);
    check_value("bus_ready", bus_ready, 1'b0);
    check_value("driving_busses", driving_busses, 1'b0);
    check_value("output_valid", output_valid, 1'b0);

    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    wait_cycles = 0;
    @(negedge clk);
    while (running !== 1'b1) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 10) abort_run("running did not rise after start");
    end

    // Host side: kernels first, then one window per pixel, with random idles
    beat = 0;
    idle_cycles = 0;
    while (beat < IN_BEATS) begin
      @(posedge clk);
      if (bus_valid && ready_seen) begin
        beat++;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
      if (idle_cycles > BEAT_TIMEOUT) begin
        abort_run("Timed out waiting for bus_ready to accept a beat");
      end
      if (beat < IN_BEATS && ready_seen && ($random(seed) & 3) != 0) begin
        present_beat(beat);
      end else begin
        bus_valid <= 1'b0;
      end
    end

    wait_cycles = 0;
    while (out_beats < OUT_BEATS) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > DONE_TIMEOUT) abort_run("Timed out waiting for the last result beat");
    end
    wait_cycles = 0;
    @(negedge clk);
    while (running !== 1'b0) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 10) abort_run("running did not fall after the last pixel");
    end

    // Extra output beats in this window are caught by the monitor
    repeat (QUIET_CYCLES) @(posedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* conv_top.f */
+incdir+design
design/conv_pkg.sv
design/bus_port_if.sv
design/bus_arbiter.sv
design/operand_loader.sv
design/mac_array.sv
design/result_unloader.sv
design/conv_top.sv
verification/clk_gen.sv
verification/conv_tb.sv

/* Makefile */
# Verilator build and run of the convolution accelerator testbench

.PHONY: all lint clean

all: obj_dir/Vconv_tb
	./obj_dir/Vconv_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

obj_dir/Vconv_tb: conv_top.f design/*.sv design/*.svh verification/*.sv
	verilator --binary --timing -Wno-fatal --top-module conv_tb -f conv_top.f -o Vconv_tb

lint:
	verilator --lint-only -Wall --timing --top-module conv_top -f conv_top.f

clean:
	rm -rf obj_dir sim.log

/* verification/conv_stim.mem */
// Rows 1-4: kernel words of output channels 0-3 (input channel 0 taps 0-8, then channel 1)
// Rows 5-20: window of pixels 0-15 in the same order; last rows: expected results, ch 0-3
0001 0001 0001 0001 0001 0001 0001 0001 0001 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0001 0001 0001 0001 0001 0001 0001 0001 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001 ffff ffff ffff ffff ffff ffff ffff ffff ffff
2000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 d000 0000 0000 0000 0000
0000 0001 0002 0003 0004 0005 0006 0007 0008 0000 0001 0002 0003 0004 0005 0006 0007 0008
0001 0002 0003 0004 0005 0006 0007 0008 0009 ffff 0000 0001 0002 0003 0004 0005 0006 0007
0002 0003 0004 0005 0006 0007 0008 0009 000a fffe ffff 0000 0001 0002 0003 0004 0005 0006
0003 0004 0005 0006 0007 0008 0009 000a 000b fffd fffe ffff 0000 0001 0002 0003 0004 0005
0004 0005 0006 0007 0008 0009 000a 000b 000c fffc fffd fffe ffff 0000 0001 0002 0003 0004
0005 0006 0007 0008 0009 000a 000b 000c 000d fffb fffc fffd fffe ffff 0000 0001 0002 0003
0006 0007 0008 0009 000a 000b 000c 000d 000e fffa fffb fffc fffd fffe ffff 0000 0001 0002
0007 0008 0009 000a 000b 000c 000d 000e 000f fff9 fffa fffb fffc fffd fffe ffff 0000 0001
0008 0009 000a 000b 000c 000d 000e 000f 0010 fff8 fff9 fffa fffb fffc fffd fffe ffff 0000
0009 000a 000b 000c 000d 000e 000f 0010 0011 fff7 fff8 fff9 fffa fffb fffc fffd fffe ffff
000a 000b 000c 000d 000e 000f 0010 0011 0012 fff6 fff7 fff8 fff9 fffa fffb fffc fffd fffe
000b 000c 000d 000e 000f 0010 0011 0012 0013 fff5 fff6 fff7 fff8 fff9 fffa fffb fffc fffd
000c 000d 000e 000f 0010 0011 0012 0013 0014 fff4 fff5 fff6 fff7 fff8 fff9 fffa fffb fffc
000d 000e 000f 0010 0011 0012 0013 0014 0015 fff3 fff4 fff5 fff6 fff7 fff8 fff9 fffa fffb
000e 000f 0010 0011 0012 0013 0014 0015 0016 fff2 fff3 fff4 fff5 fff6 fff7 fff8 fff9 fffa
000f 0010 0011 0012 0013 0014 0015 0016 0017 fff1 fff2 fff3 fff4 fff5 fff6 fff7 fff8 fff9
0024 0024 0000 8000 002d 001b 0012 9000 0036 0012 0024 e000 003f 0009 0036 3000
0048 0000 0048 7fff 0051 fff7 005a 7fff 005a ffee 006c 7fff 0063 ffe5 007e 7fff
006c ffdc 0090 7fff 0075 ffd3 00a2 7fff 007e ffca 00b4 7fff 0087 ffc1 00c6 7fff
0090 ffb8 00d8 7fff 0099 ffaf 00ea 7fff 00a2 ffa6 00fc 7fff 00ab ff9d 010e 7fff
